//--- common/isa_pkg.sv
package isa_pkg;

    // ********************
    // basic widths
    // ********************

    localparam int word_width = 16;
    localparam int num_regs   = 8;

    typedef logic [word_width-1:0] word_t;
    typedef logic [15:0]           inst_t;
    typedef logic [2:0]            reg_addr_t;
    typedef logic [4:0]            opcode_t;

    // ********************
    // field positions
    // ********************

    localparam int op_msb     = 15;
    localparam int op_lsb     = 11;
    localparam int rx_msb     = 10;
    localparam int rx_lsb     = 8;
    localparam int ry_msb     = 7;
    localparam int ry_lsb     = 5;
    localparam int rz_msb     = 4;
    localparam int rz_lsb     = 2;
    // immediates start at bit 0
    localparam int imm8_msb   = 7;
    localparam int imm11_msb  = 10;
    // function fields of the register groups
    localparam int funct2_msb = 1;
    localparam int funct5_msb = 4;

    // ********************
    // major opcodes
    // ********************

    localparam opcode_t op_nop   = 5'b00001;
    localparam opcode_t op_b     = 5'b00010;
    localparam opcode_t op_beqz  = 5'b00100;
    localparam opcode_t op_bnez  = 5'b00101;
    localparam opcode_t op_addiu = 5'b01001;
    localparam opcode_t op_li    = 5'b01101;
    // addu / subu, result in rz
    localparam opcode_t op_rrr   = 5'b11100;
    // and / or, result in rx
    localparam opcode_t op_logic = 5'b11101;

    // function codes
    localparam logic [1:0] funct_addu = 2'b01;
    localparam logic [1:0] funct_subu = 2'b11;
    localparam logic [4:0] funct_and  = 5'b01100;
    localparam logic [4:0] funct_or   = 5'b01101;

endpackage

//--- common/pipe_pkg.sv
package pipe_pkg;

    // ********************
    // execute selections
    // ********************

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        br_none,
        br_always,
        br_if_zero,
        br_if_nonzero
    } branch_t;

    // ********************
    // pipeline structs
    // ********************

    // decoded control, travels decode -> execute
    typedef struct packed {
        alu_op_t            alu_op;
        logic               b_from_imm;
        logic               reg_write;
        isa_pkg::reg_addr_t wb_addr;
        branch_t            branch;
    } ctrl_t;

    // register write port, also seen outside the core
    typedef struct packed {
        logic               en;
        isa_pkg::reg_addr_t addr;
        isa_pkg::word_t     data;
    } writeback_t;

    // taken branch back to fetch
    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } redirect_t;

endpackage

//--- rtl/fetch_stage.sv
module fetch_stage #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic                clk_50MHz,
    input  logic                rst,
    input  pipe_pkg::redirect_t redirect,
    input  isa_pkg::inst_t      inst,
    output isa_pkg::word_t      pc,
    output isa_pkg::inst_t      id_inst,
    output isa_pkg::word_t      id_pc_next,
    output logic                id_valid
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t pc_plus1;
    word_t pc_sel;

    // ********************
    // next pc
    // ********************

    assign pc_plus1 = pc + word_t'(1);

    // a taken branch in execute wins over sequential fetch
    assign pc_sel = redirect.taken ? redirect.target : pc_plus1;

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_sel;
        end
    end

    // ********************
    // fetch/decode register
    // ********************

    // squash the instruction fetched alongside a taken branch
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= ~redirect.taken;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        id_inst    <= inst;
        id_pc_next <= pc_plus1;
    end

endmodule

//--- rtl/instruction_decoder.sv
module instruction_decoder (
    input  isa_pkg::inst_t  inst,
    output pipe_pkg::ctrl_t ctrl,
    output isa_pkg::word_t  imm
);

    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_t   op;
    reg_addr_t rx;
    reg_addr_t rz;
    word_t     zext8;
    word_t     sext8;
    word_t     sext11;

    assign op = inst[op_msb:op_lsb];
    assign rx = inst[rx_msb:rx_lsb];
    assign rz = inst[rz_msb:rz_lsb];

    // ********************
    // immediate forms
    // ********************

    assign zext8  = {8'b0, inst[imm8_msb:0]};
    assign sext8  = {{8{inst[imm8_msb]}}, inst[imm8_msb:0]};
    assign sext11 = {{5{inst[imm11_msb]}}, inst[imm11_msb:0]};

    // ********************
    // control decode
    // ********************

    always_comb begin
        // default is a bubble: no write, no branch
        ctrl.alu_op     = alu_add;
        ctrl.b_from_imm = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.wb_addr    = rx;
        ctrl.branch     = br_none;
        imm             = sext8;

        case (op)
            op_nop: begin
            end
            op_addiu: begin
                ctrl.b_from_imm = 1'b1;
                ctrl.reg_write  = 1'b1;
            end
            op_li: begin
                ctrl.alu_op     = alu_pass_b;
                ctrl.b_from_imm = 1'b1;
                ctrl.reg_write  = 1'b1;
                imm             = zext8;
            end
            op_b: begin
                ctrl.branch = br_always;
                imm         = sext11;
            end
            op_beqz: ctrl.branch = br_if_zero;
            op_bnez: ctrl.branch = br_if_nonzero;
            op_rrr: begin
                ctrl.wb_addr = rz;
                case (inst[funct2_msb:0])
                    funct_addu: ctrl.reg_write = 1'b1;
                    funct_subu: begin
                        ctrl.alu_op    = alu_sub;
                        ctrl.reg_write = 1'b1;
                    end
                    default: ;
                endcase
            end
            op_logic: begin
                // funct sits in the low bits, rx is both source and target
                if (inst[funct5_msb:0] == funct_and) begin
                    ctrl.alu_op    = alu_and;
                    ctrl.reg_write = 1'b1;
                end else if (inst[funct5_msb:0] == funct_or) begin
                    ctrl.alu_op    = alu_or;
                    ctrl.reg_write = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/register_file.sv
module register_file (
    input  logic                 clk_50MHz,
    input  logic                 rst,
    input  isa_pkg::reg_addr_t   raddr_a,
    input  isa_pkg::reg_addr_t   raddr_b,
    input  pipe_pkg::writeback_t wb,
    output isa_pkg::word_t       rdata_a,
    output isa_pkg::word_t       rdata_b
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t regs [num_regs];

    // ********************
    // write port
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // ********************
    // read ports
    // ********************

    // same-cycle write seen by the reader
    assign rdata_a = (wb.en && wb.addr == raddr_a) ? wb.data : regs[raddr_a];
    assign rdata_b = (wb.en && wb.addr == raddr_b) ? wb.data : regs[raddr_b];

endmodule

//--- execute/execute_stage.sv
module execute_stage (
    input  logic                 clk_50MHz,
    input  logic                 rst,
    input  logic                 id_valid,
    input  pipe_pkg::ctrl_t      id_ctrl,
    input  isa_pkg::word_t       id_imm,
    input  isa_pkg::word_t       id_pc_next,
    input  isa_pkg::reg_addr_t   id_src_a,
    input  isa_pkg::reg_addr_t   id_src_b,
    input  isa_pkg::word_t       rdata_a,
    input  isa_pkg::word_t       rdata_b,
    output pipe_pkg::redirect_t  redirect,
    output pipe_pkg::writeback_t wb
);

    import isa_pkg::*;
    import pipe_pkg::*;

    // decode/execute register
    logic      ex_valid;
    ctrl_t     ex_ctrl;
    word_t     ex_imm;
    word_t     ex_pc_next;
    reg_addr_t ex_src_a;
    reg_addr_t ex_src_b;
    word_t     ex_rdata_a;
    word_t     ex_rdata_b;

    // execute/writeback register
    logic      wb_en_q;
    reg_addr_t wb_addr_q;
    word_t     wb_data_q;

    word_t     op_a;
    word_t     op_b;
    word_t     alu_b;
    word_t     alu_result;
    logic      cond_met;
    logic      taken;

    // ********************
    // decode/execute register
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            ex_valid <= 1'b0;
        end else begin
            // younger instruction behind a taken branch is dropped
            ex_valid <= id_valid & ~taken;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        ex_ctrl    <= id_ctrl;
        ex_imm     <= id_imm;
        ex_pc_next <= id_pc_next;
        ex_src_a   <= id_src_a;
        ex_src_b   <= id_src_b;
        ex_rdata_a <= rdata_a;
        ex_rdata_b <= rdata_b;
    end

    // ********************
    // forwarding
    // ********************

    // only the previous instruction can be missing from the read data,
    // anything older went through the register file write-through
    assign op_a = (wb_en_q && wb_addr_q == ex_src_a) ? wb_data_q : ex_rdata_a;
    assign op_b = (wb_en_q && wb_addr_q == ex_src_b) ? wb_data_q : ex_rdata_b;

    // ********************
    // alu
    // ********************

    assign alu_b = ex_ctrl.b_from_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_ctrl.alu_op)
            alu_sub:    alu_result = op_a - alu_b;
            alu_and:    alu_result = op_a & alu_b;
            alu_or:     alu_result = op_a | alu_b;
            alu_pass_b: alu_result = alu_b;
            default:    alu_result = op_a + alu_b;
        endcase
    end

    // ********************
    // branch decision
    // ********************

    always_comb begin
        case (ex_ctrl.branch)
            br_always:     cond_met = 1'b1;
            br_if_zero:    cond_met = (op_a == '0);
            br_if_nonzero: cond_met = (op_a != '0);
            default:       cond_met = 1'b0;
        endcase
    end

    assign taken    = ex_valid & cond_met;
    // offset is relative to the following instruction
    assign redirect = '{taken: taken, target: ex_pc_next + ex_imm};

    // ********************
    // execute/writeback register
    // ********************

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb_en_q <= 1'b0;
        end else begin
            wb_en_q <= ex_valid & ex_ctrl.reg_write;
        end
    end

    always_ff @(posedge clk_50MHz) begin
        wb_addr_q <= ex_ctrl.wb_addr;
        wb_data_q <= alu_result;
    end

    assign wb = '{en: wb_en_q, addr: wb_addr_q, data: wb_data_q};

endmodule

//--- rtl/cpu_core.sv
module cpu_core #(
    parameter isa_pkg::word_t reset_pc = '0
) (
    input  logic                 clk_50MHz,
    input  logic                 rst,
    input  isa_pkg::inst_t       inst,
    output isa_pkg::word_t       pc,
    output pipe_pkg::writeback_t wb
);

    import isa_pkg::*;
    import pipe_pkg::*;

    redirect_t redirect;
    inst_t     id_inst;
    word_t     id_pc_next;
    logic      id_valid;
    ctrl_t     id_ctrl;
    word_t     id_imm;
    word_t     rdata_a;
    word_t     rdata_b;

    // ********************
    // fetch
    // ********************

    fetch_stage #(
        .reset_pc(reset_pc)
    ) u_fetch (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .redirect  (redirect),
        .inst      (inst),
        .pc        (pc),
        .id_inst   (id_inst),
        .id_pc_next(id_pc_next),
        .id_valid  (id_valid)
    );

    // ********************
    // decode, decoder and register file side by side
    // ********************

    instruction_decoder u_decoder (
        .inst(id_inst),
        .ctrl(id_ctrl),
        .imm (id_imm)
    );

    register_file u_regs (
        .clk_50MHz(clk_50MHz),
        .rst      (rst),
        .raddr_a  (id_inst[rx_msb:rx_lsb]),
        .raddr_b  (id_inst[ry_msb:ry_lsb]),
        .wb       (wb),
        .rdata_a  (rdata_a),
        .rdata_b  (rdata_b)
    );

    // ********************
    // execute and writeback
    // ********************

    execute_stage u_execute (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .id_valid  (id_valid),
        .id_ctrl   (id_ctrl),
        .id_imm    (id_imm),
        .id_pc_next(id_pc_next),
        .id_src_a  (id_inst[rx_msb:rx_lsb]),
        .id_src_b  (id_inst[ry_msb:ry_lsb]),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .redirect  (redirect),
        .wb        (wb)
    );

endmodule

//--- verif/cpu_checker.sv
module cpu_checker #(
    parameter isa_pkg::word_t reset_pc = '0,
    parameter int             prog_len = 64
) (
    input  logic                 clk_50MHz,
    input  logic                 rst,
    input  isa_pkg::word_t       pc,
    input  pipe_pkg::writeback_t wb,
    input  isa_pkg::inst_t       prog [prog_len],
    input  logic                 run_done,
    output logic                 report_ready,
    output int                   fail_count
);

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int    idx_w     = $clog2(prog_len);
    localparam word_t prog_end  = reset_pc + word_t'(prog_len);
    localparam int    num_tests = 5;
    localparam int    t_reset   = 0;
    localparam int    t_alu     = 1;
    localparam int    t_taken   = 2;
    localparam int    t_untaken = 3;
    localparam int    t_done    = 4;

    int   checks [num_tests] = '{default: 0};
    int   errors [num_tests] = '{default: 0};
    int   total_errors       = 0;
    int   model_writes       = 0;
    int   seen_writes        = 0;
    int   taken_count        = 0;
    int   untaken_count      = 0;
    logic started            = 1'b0;
    logic ready_q            = 1'b0;

    // expected register writes in program order and the test of each
    reg_addr_t exp_addr [$];
    word_t     exp_data [$];
    int        exp_test [$];

    assign report_ready = ready_q;
    assign fail_count   = total_errors;

    function automatic string test_name(input int t);
        case (t)
            t_reset:   return "reset";
            t_alu:     return "register and immediate results";
            t_taken:   return "taken branches";
            t_untaken: return "untaken branches";
            default:   return "completion";
        endcase
    endfunction

    task automatic mismatch(input int t, input string sig, input word_t exp, input word_t act);
        $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, sig, exp, act);
        errors[t]++;
        total_errors++;
    endtask

    task automatic report_test(input int t);
        $display("test %0d %s: %0d checks, %0d errors, %s", t + 1, test_name(t),
                 checks[t], errors[t], (errors[t] == 0) ? "pass" : "fail");
    endtask

    // ********************
    // ISA model
    // ********************

    task automatic run_model();
        word_t     regs [num_regs];
        word_t     mpc;
        word_t     next_pc;
        word_t     off;
        inst_t     ins;
        word_t     a;
        word_t     b;
        reg_addr_t wa;
        word_t     wd;
        logic      wr;
        int        tag;
        int        steps;
        for (int i = 0; i < num_regs; i++) begin
            regs[i] = '0;
        end
        mpc   = reset_pc;
        tag   = t_alu;
        steps = 0;
        while (mpc >= reset_pc && mpc < prog_end && steps < 4 * prog_len) begin
            off     = mpc - reset_pc;
            ins     = prog[off[idx_w-1:0]];
            a       = regs[ins[rx_msb:rx_lsb]];
            b       = regs[ins[ry_msb:ry_lsb]];
            next_pc = mpc + 16'd1;
            wr      = 1'b0;
            wa      = ins[rx_msb:rx_lsb];
            wd      = '0;
            case (ins[op_msb:op_lsb])
                op_rrr: begin
                    wa = ins[rz_msb:rz_lsb];
                    wr = (ins[1:0] == funct_addu) || (ins[1:0] == funct_subu);
                    wd = (ins[1:0] == funct_subu) ? a - b : a + b;
                end
                op_logic: begin
                    wr = (ins[4:0] == funct_and) || (ins[4:0] == funct_or);
                    wd = (ins[4:0] == funct_and) ? (a & b) : (a | b);
                end
                op_li: begin
                    wr = 1'b1;
                    wd = {8'b0, ins[7:0]};
                end
                op_addiu: begin
                    wr = 1'b1;
                    wd = a + {{8{ins[7]}}, ins[7:0]};
                end
                op_b: begin
                    next_pc = next_pc + {{5{ins[10]}}, ins[10:0]};
                    taken_count++;
                    tag = t_taken;
                end
                op_beqz, op_bnez: begin
                    if ((a == '0) == (ins[op_msb:op_lsb] == op_beqz)) begin
                        next_pc = next_pc + {{8{ins[7]}}, ins[7:0]};
                        taken_count++;
                        tag = t_taken;
                    end else begin
                        untaken_count++;
                        tag = t_untaken;
                    end
                end
                default: ;
            endcase
            if (wr) begin
                regs[wa] = wd;
                exp_addr.push_back(wa);
                exp_data.push_back(wd);
                exp_test.push_back(tag);
                model_writes++;
                tag = t_alu;
            end
            mpc = next_pc;
            steps++;
        end
    endtask

    // ********************
    // comparison
    // ********************

    task automatic compare_writeback();
        int        t;
        reg_addr_t ea;
        word_t     ed;
        seen_writes++;
        if (exp_addr.size() == 0) begin
            $display("writeback to r%0d at time %0t, but the model has no more register writes",
                     wb.addr, $time);
            errors[t_done]++;
            total_errors++;
        end else begin
            ea = exp_addr.pop_front();
            ed = exp_data.pop_front();
            t  = exp_test.pop_front();
            checks[t]++;
            if (wb.addr !== ea) begin
                mismatch(t, "wb.addr", {13'b0, ea}, {13'b0, wb.addr});
            end
            if (wb.data !== ed) begin
                mismatch(t, "wb.data", ed, wb.data);
            end
        end
    endtask

    task automatic final_report();
        checks[t_done]++;
        if (seen_writes != model_writes) begin
            $display("ERR time=%0t signal=writeback_count expected=%0d actual=%0d",
                     $time, model_writes, seen_writes);
            errors[t_done]++;
            total_errors++;
        end
        for (int t = t_alu; t < num_tests; t++) begin
            report_test(t);
        end
        $display("%0d writebacks, %0d taken and %0d untaken branches, %0d errors in %0d tests",
                 seen_writes, taken_count, untaken_count, total_errors, num_tests);
        ready_q = 1'b1;
    endtask

    always @(posedge clk_50MHz) begin
        if (!rst) begin
            checks[t_reset]++;
            if (wb.en !== 1'b0) begin
                mismatch(t_reset, "wb.en", 16'd0, {15'b0, wb.en});
            end
        end else begin
            // first cycle after release
            if (!started) begin
                started = 1'b1;
                run_model();
                checks[t_reset]++;
                if (pc !== reset_pc) begin
                    mismatch(t_reset, "pc", reset_pc, pc);
                end
                report_test(t_reset);
            end
            if (wb.en) begin
                compare_writeback();
            end
            if (run_done && !ready_q) begin
                final_report();
            end
        end
    end

endmodule

//--- verif/tb_cpu_core.sv
module tb_cpu_core;

    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam word_t reset_pc       = 16'h0020;
    localparam int    prog_len       = 64;
    localparam int    idx_w          = $clog2(prog_len);
    localparam word_t prog_end       = reset_pc + word_t'(prog_len);
    localparam int    timeout_cycles = 2000;
    localparam int    report_timeout = 20;
    // long enough past the end for the last redirect and writeback
    localparam int    drain_cycles   = 5;
    localparam inst_t nop_inst       = {op_nop, 11'b0};

    logic       clk_50MHz = 1'b0;
    logic       rst;
    inst_t      inst;
    word_t      pc;
    writeback_t wb;
    logic       run_done;
    logic       report_ready;
    int         fail_count;

    inst_t       prog [prog_len];
    logic [31:0] lfsr_state;
    word_t       pc_off;
    logic [idx_w-1:0] prog_idx;

    always #10 clk_50MHz = ~clk_50MHz;

    // ********************
    // instruction memory
    // ********************

    // same-cycle read, NOPs outside the program
    always_comb begin
        pc_off   = pc - reset_pc;
        prog_idx = pc_off[idx_w-1:0];
        if (pc >= reset_pc && pc < prog_end) begin
            inst = prog[prog_idx];
        end else begin
            inst = nop_inst;
        end
    end

    cpu_core #(
        .reset_pc(reset_pc)
    ) DUT (
        .clk_50MHz(clk_50MHz),
        .rst      (rst),
        .inst     (inst),
        .pc       (pc),
        .wb       (wb)
    );

    cpu_checker #(
        .reset_pc(reset_pc),
        .prog_len(prog_len)
    ) u_checker (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .pc          (pc),
        .wb          (wb),
        .prog        (prog),
        .run_done    (run_done),
        .report_ready(report_ready),
        .fail_count  (fail_count)
    );

    // ********************
    // random program
    // ********************

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        return state[0] ? (shifted ^ 32'h80200003) : shifted;
    endfunction

    task automatic draw_bits(input int count, output logic [10:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[9:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic build_program();
        logic [10:0] kind;
        logic [10:0] rx;
        logic [10:0] ry;
        logic [10:0] rz;
        logic [10:0] val;
        for (int i = 0; i < prog_len; i++) begin
            draw_bits(3, kind);
            draw_bits(3, rx);
            draw_bits(3, ry);
            draw_bits(3, rz);
            case (kind[2:0])
                3'd0: prog[i] = {op_rrr, rx[2:0], ry[2:0], rz[2:0], funct_addu};
                3'd1: prog[i] = {op_rrr, rx[2:0], ry[2:0], rz[2:0], funct_subu};
                3'd2: prog[i] = {op_logic, rx[2:0], ry[2:0], funct_and};
                3'd3: prog[i] = {op_logic, rx[2:0], ry[2:0], funct_or};
                3'd4: begin
                    draw_bits(8, val);
                    prog[i] = {op_li, rx[2:0], val[7:0]};
                end
                3'd5: begin
                    draw_bits(8, val);
                    prog[i] = {op_addiu, rx[2:0], val[7:0]};
                end
                3'd6: begin
                    // forward offsets only, so the program always ends
                    draw_bits(3, val);
                    prog[i] = {val[2] ? op_bnez : op_beqz, rx[2:0], 6'b0, val[1:0]};
                end
                default: begin
                    draw_bits(3, val);
                    prog[i] = val[2] ? {op_b, 9'b0, val[1:0]} : nop_inst;
                end
            endcase
        end
    endtask

    // ********************
    // run control
    // ********************

    task automatic wait_program_end(output logic ok);
        int streak;
        int cycles;
        streak = 0;
        cycles = 0;
        while (streak < drain_cycles && cycles < timeout_cycles) begin
            @(posedge clk_50MHz);
            cycles++;
            if (pc >= prog_end) begin
                streak++;
            end else begin
                streak = 0;
            end
        end
        ok = (streak >= drain_cycles);
        if (!ok) begin
            $display("timeout: pc did not leave the program within %0d cycles", timeout_cycles);
        end
    endtask

    task automatic wait_report(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (!ok && cycles < report_timeout) begin
            @(negedge clk_50MHz);
            cycles++;
            ok = report_ready;
        end
        if (!ok) begin
            $display("timeout: the checker did not finish its report");
        end
    endtask

    initial begin
        logic ok;
        rst        = 1'b0;
        run_done   = 1'b0;
        lfsr_state = 32'hfcd637e5;
        build_program();

        repeat (8) @(negedge clk_50MHz);
        rst = 1'b1;

        wait_program_end(ok);
        if (ok) begin
            @(negedge clk_50MHz);
            run_done = 1'b1;
            wait_report(ok);
        end

        if (ok && fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
common/isa_pkg.sv
common/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/instruction_decoder.sv
rtl/register_file.sv
execute/execute_stage.sv
rtl/cpu_core.sv
verif/cpu_checker.sv
verif/tb_cpu_core.sv

//--- run_sim.sh
#!/bin/sh
# build the cpu_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_cpu_core -f src.f \
    -Mdir obj_dir -o sim_cpu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cpu_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
